// File: hdl/uart_word_pkg.sv
package uart_word_pkg;

    // serial byte and assembled word widths
    localparam int byte_width = 8;
    localparam int word_width = 16;

    // clock cycles per serial bit, kept small for short runs
    localparam int baud_div = 8;
    localparam int baud_cnt_w = $clog2(baud_div);

    // output queue and credit pool sizing
    localparam int queue_depth = 4;
    localparam int queue_aw = $clog2(queue_depth);
    localparam int credit_max = 4;
    localparam int credit_w = $clog2(credit_max + 1);

    typedef logic [baud_cnt_w-1:0]         baud_cnt_t;
    typedef logic [$clog2(byte_width)-1:0] bit_cnt_t;
    typedef logic [queue_aw-1:0]           qptr_t;
    // one extra bit so a full queue is distinct from empty
    typedef logic [queue_aw:0]             qcount_t;
    typedef logic [credit_w-1:0]           credit_t;

    // mid-bit sample points, counted from zero
    localparam baud_cnt_t baud_half = baud_cnt_t'(baud_div / 2 - 1);
    localparam baud_cnt_t baud_last = baud_cnt_t'(baud_div - 1);
    localparam bit_cnt_t  bit_last = bit_cnt_t'(byte_width - 1);
    localparam qcount_t   queue_full_cnt = qcount_t'(queue_depth);
    localparam credit_t   credit_init = credit_t'(credit_max);

    // one received byte, frame_err set on a low stop bit
    typedef struct packed {
        logic [byte_width-1:0] data;
        logic                  frame_err;
    } rx_byte_t;

    // one assembled word, frame_err is the OR over both bytes
    typedef struct packed {
        logic [word_width-1:0] data;
        logic                  frame_err;
    } word_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    // which half of the word comes next
    typedef enum logic {
        asm_low,
        asm_high
    } asm_state_t;

endpackage

// File: hdl/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rxd,
    output logic                    byte_valid,
    output uart_word_pkg::rx_byte_t byte_out
);

    // two-flop synchronizer, line idles high
    logic [1:0] rxd_sync;
    // last synced value, for start edge detect
    logic       rxd_prev;
    logic       rxd_fall;
    // synced line value used for all samples
    logic       rxd_bit;

    uart_word_pkg::rx_state_t state;
    uart_word_pkg::baud_cnt_t baud_cnt;
    uart_word_pkg::bit_cnt_t  bit_cnt;
    // mid-bit tick inside data and stop bits
    logic                     bit_tick;

    // data bits collected LSB first
    logic [uart_word_pkg::byte_width-1:0] shift_reg;

    assign rxd_bit = rxd_sync[1];
    assign rxd_fall = rxd_prev & ~rxd_bit;
    assign bit_tick = (baud_cnt == uart_word_pkg::baud_last);

    always_ff @(posedge clk) begin
        if (!rst) begin
            rxd_sync <= 2'b11;
            rxd_prev <= 1'b1;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rxd_prev <= rxd_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= uart_word_pkg::rx_idle;
            baud_cnt <= '0;
            bit_cnt <= '0;
            byte_valid <= 1'b0;
        end else begin
            // strobe lasts a single cycle
            byte_valid <= 1'b0;
            case (state)
                uart_word_pkg::rx_idle: begin
                    baud_cnt <= '0;
                    bit_cnt <= '0;
                    if (rxd_fall) begin
                        state <= uart_word_pkg::rx_start;
                    end
                end
                uart_word_pkg::rx_start: begin
                    // half a bit in, the start bit must still be low
                    if (baud_cnt == uart_word_pkg::baud_half) begin
                        baud_cnt <= '0;
                        if (!rxd_bit) begin
                            state <= uart_word_pkg::rx_data;
                        end else begin
                            // glitch on the line, not a real start
                            state <= uart_word_pkg::rx_idle;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_word_pkg::rx_data: begin
                    if (bit_tick) begin
                        baud_cnt <= '0;
                        if (bit_cnt == uart_word_pkg::bit_last) begin
                            bit_cnt <= '0;
                            state <= uart_word_pkg::rx_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_word_pkg::rx_stop: begin
                    if (bit_tick) begin
                        // byte goes out even with a bad stop bit
                        baud_cnt <= '0;
                        byte_valid <= 1'b1;
                        state <= uart_word_pkg::rx_idle;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= uart_word_pkg::rx_idle;
                end
            endcase
        end
    end

    // datapath, follows the FSM sample points
    always_ff @(posedge clk) begin
        if (state == uart_word_pkg::rx_data && bit_tick) begin
            // new bit enters at the top, first bit ends at bit 0
            shift_reg <= {rxd_bit, shift_reg[uart_word_pkg::byte_width-1:1]};
        end
        if (state == uart_word_pkg::rx_stop && bit_tick) begin
            byte_out.data <= shift_reg;
            // stop bit should be high
            byte_out.frame_err <= ~rxd_bit;
        end
    end

endmodule

// File: hdl/uart_word_asm.sv
`timescale 1ns/100ps

module uart_word_asm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    byte_valid,
    input  uart_word_pkg::rx_byte_t byte_in,
    output logic                    asm_valid,
    output uart_word_pkg::word_t    asm_word
);

    // which byte of the pair comes next
    uart_word_pkg::asm_state_t state;
    // first byte of the pair, held until its partner arrives
    uart_word_pkg::rx_byte_t   low_byte;

    // strobes for the two halves
    logic take_low;
    logic take_high;

    assign take_low = byte_valid && (state == uart_word_pkg::asm_low);
    assign take_high = byte_valid && (state == uart_word_pkg::asm_high);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= uart_word_pkg::asm_low;
            asm_valid <= 1'b0;
        end else begin
            // single cycle strobe
            asm_valid <= 1'b0;
            if (byte_valid) begin
                case (state)
                    uart_word_pkg::asm_low: begin
                        state <= uart_word_pkg::asm_high;
                    end
                    uart_word_pkg::asm_high: begin
                        // pair complete
                        asm_valid <= 1'b1;
                        state <= uart_word_pkg::asm_low;
                    end
                    default: begin
                        state <= uart_word_pkg::asm_low;
                    end
                endcase
            end
        end
    end

    // payload side
    always_ff @(posedge clk) begin
        if (take_low) begin
            low_byte <= byte_in;
        end
        if (take_high) begin
            // low byte arrived first, second byte is the upper half
            asm_word.data <= {byte_in.data, low_byte.data};
            // word is flagged if either byte had a bad stop bit
            asm_word.frame_err <= byte_in.frame_err | low_byte.frame_err;
        end
    end

endmodule

// File: hdl/word_credit_tx.sv
`timescale 1ns/100ps

module word_credit_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 asm_valid,
    input  uart_word_pkg::word_t asm_word,
    input  logic                 credit_return,
    output logic                 word_valid,
    output uart_word_pkg::word_t word_out,
    output logic                 overflow
);

    // circular word queue
    uart_word_pkg::word_t   queue_mem [uart_word_pkg::queue_depth];
    uart_word_pkg::qptr_t   wr_ptr;
    uart_word_pkg::qptr_t   rd_ptr;
    uart_word_pkg::qcount_t count;

    // credits still held toward the sink
    uart_word_pkg::credit_t credits;

    logic queue_empty;
    logic queue_full;
    logic credit_ok;
    logic bypass;
    logic pop;
    logic push;
    logic issue;
    logic drop;

    assign queue_empty = (count == '0);
    assign queue_full = (count == uart_word_pkg::queue_full_cnt);
    assign credit_ok = (credits != '0);

    // empty queue and a credit in hand, new word goes straight out
    assign bypass = asm_valid && queue_empty && credit_ok;
    // otherwise the oldest queued word leaves when a credit is held
    assign pop = !queue_empty && credit_ok;
    assign issue = bypass | pop;

    // fullness is judged before this cycle's pop
    assign push = asm_valid && !bypass && !queue_full;
    assign drop = asm_valid && !bypass && queue_full;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credits <= uart_word_pkg::credit_init;
            word_valid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            word_valid <= issue;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + uart_word_pkg::qcount_t'(push) - uart_word_pkg::qcount_t'(pop);
            // spend and return may land in the same cycle
            case ({issue, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            // sticky until reset
            if (drop) begin
                overflow <= 1'b1;
            end
        end
    end

    // storage and output register
    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= asm_word;
        end
        if (bypass) begin
            word_out <= asm_word;
        end else if (pop) begin
            word_out <= queue_mem[rd_ptr];
        end
    end

endmodule

// File: hdl/uart_word_top.sv
`timescale 1ns/100ps

module uart_word_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rxd,
    input  logic                 credit_return,
    output logic                 word_valid,
    output uart_word_pkg::word_t word_out,
    output logic                 overflow
);

    // receiver to assembler
    logic                    byte_valid;
    uart_word_pkg::rx_byte_t byte_out;

    // assembler to credit sender
    logic                    asm_valid;
    uart_word_pkg::word_t    asm_word;

    uart_rx u_rx (
        .clk        (clk),
        .rst        (rst),
        .rxd        (rxd),
        .byte_valid (byte_valid),
        .byte_out   (byte_out)
    );

    uart_word_asm u_asm (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_in    (byte_out),
        .asm_valid  (asm_valid),
        .asm_word   (asm_word)
    );

    // queue and credit gate toward the sink
    word_credit_tx u_credit_tx (
        .clk           (clk),
        .rst           (rst),
        .asm_valid     (asm_valid),
        .asm_word      (asm_word),
        .credit_return (credit_return),
        .word_valid    (word_valid),
        .word_out      (word_out),
        .overflow      (overflow)
    );

endmodule

// File: tests/tb_uart_word_top.sv
`timescale 1ns/100ps

module tb_uart_word_top;

    localparam int clk_period = 20;
    // cycles allowed for any single wait
    localparam int wait_limit = 2000;

    logic                 clk;
    logic                 rst;
    logic                 rxd;
    logic                 credit_return;
    logic                 word_valid;
    uart_word_pkg::word_t word_out;
    logic                 overflow;

    integer seed;
    // separate stream for the sink, draws at the same edges as the stimulus
    integer sink_seed;
    int     value_errors = 0;
    int     timeout_errors = 0;

    // reference model, words the sink should see, oldest first
    uart_word_pkg::word_t exp_q[$];
    // words the model expects the DUT to take, and those it drops
    int accepted = 0;
    int dropped = 0;

    // sink side, written only by the monitor block
    int received = 0;
    int returned = 0;
    int outstanding = 0;
    // sink holds every credit while set
    logic withhold = 1'b0;
    // handshake so a reset voids credits still out
    int clear_req = 0;
    int clear_seen = 0;

    uart_word_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .rxd           (rxd),
        .credit_return (credit_return),
        .word_valid    (word_valid),
        .word_out      (word_out),
        .overflow      (overflow)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // monitor and credit sink, outputs are stable at the falling edge
    always @(negedge clk) begin
        uart_word_pkg::word_t exp_word;
        if (clear_req != clear_seen) begin
            // sender reloaded its credits, nothing is owed back
            returned = returned + outstanding;
            outstanding = 0;
            clear_seen = clear_req;
        end
        if (word_valid) begin
            received++;
            outstanding++;
            assert (exp_q.size() != 0) else begin
                value_errors++;
                $display("FAIL %0t: a word arrived while the model expected none", $time);
            end
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                assert (word_out == exp_word) else begin
                    value_errors++;
                    $display("FAIL %0t: word %h err %b, expected %h err %b", $time,
                             word_out.data, word_out.frame_err,
                             exp_word.data, exp_word.frame_err);
                end
            end
            // never more words than the initial pool plus returns
            assert (received <= uart_word_pkg::credit_max + returned) else begin
                value_errors++;
                $display("FAIL %0t: %0d words sent on %0d returned credits", $time,
                         received, returned);
            end
        end
        if (rst && !withhold && outstanding > 0 && (($random(sink_seed) & 3) != 0)) begin
            credit_return = 1'b1;
            outstanding--;
            returned++;
        end else begin
            credit_return = 1'b0;
        end
    end

    // one serial bit, held baud_div cycles
    task automatic drive_bit(input logic level);
        int n;
        for (n = 0; n < uart_word_pkg::baud_div; n++) begin
            @(negedge clk);
            rxd = level;
        end
    endtask

    task automatic idle_bits(input int bits);
        int n;
        for (n = 0; n < bits; n++) begin
            drive_bit(1'b1);
        end
    endtask

    // 8N1 frame, data LSB first, stop bit pulled low on request
    task automatic send_byte(input logic [7:0] data, input logic bad_stop);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < uart_word_pkg::byte_width; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(~bad_stop);
    endtask

    // queue full in the model means the DUT drops the word
    task automatic commit_word(input uart_word_pkg::word_t w);
        if (accepted - received >= uart_word_pkg::queue_depth) begin
            dropped++;
        end else begin
            accepted++;
            exp_q.push_back(w);
        end
    endtask

    task automatic send_word();
        logic [7:0]           lo;
        logic [7:0]           hi;
        logic                 lo_err;
        logic                 hi_err;
        uart_word_pkg::word_t w;
        lo = 8'($random(seed));
        hi = 8'($random(seed));
        // roughly one byte in eight gets a bad stop bit
        lo_err = (($random(seed) & 7) == 0);
        hi_err = (($random(seed) & 7) == 0);
        send_byte(lo, lo_err);
        idle_bits(1 + ($random(seed) & 3));
        send_byte(hi, hi_err);
        // first byte is the low half
        w.data = {hi, lo};
        w.frame_err = lo_err | hi_err;
        // word reaches the sender a cycle after this edge
        @(posedge clk);
        commit_word(w);
        idle_bits(1 + ($random(seed) & 3));
    endtask

    task automatic drain_expected(input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (exp_q.size() != 0 && n < wait_limit);
        assert (exp_q.size() == 0) else begin
            timeout_errors++;
            $display("%0t: timed out in %s with %0d words never delivered", $time, what,
                     exp_q.size());
        end
    endtask

    task automatic collect_words(input int target, input string what);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (received < target && n < wait_limit);
        assert (received >= target) else begin
            timeout_errors++;
            $display("%0t: timed out in %s waiting for word %0d", $time, what, target);
        end
    endtask

    // sink gives back everything it was sent
    task automatic settle_credits();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (outstanding != 0 && n < wait_limit);
        assert (outstanding == 0) else begin
            timeout_errors++;
            $display("%0t: timed out with %0d credits never returned", $time, outstanding);
        end
    endtask

    task automatic watch_overflow();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!overflow && n < wait_limit);
        assert (overflow) else begin
            timeout_errors++;
            $display("%0t: timed out waiting for the overflow flag", $time);
        end
    endtask

    task automatic expect_count(input int got, input int want, input string what);
        assert (got == want) else begin
            value_errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // two cycles low, sink forgets outstanding credits meanwhile
    task automatic pulse_reset();
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        clear_req++;
        @(negedge clk);
        @(negedge clk);
        rst = 1'b1;
    endtask

    initial begin
        int base;
        int i;
        seed = 30;
        sink_seed = 30;
        rst = 1'b0;
        rxd = 1'b1;
        credit_return = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b1;
        idle_bits(2);

        // random traffic, sink returns credits freely
        for (i = 0; i < 20; i++) begin
            send_word();
        end
        drain_expected("random traffic");
        settle_credits();

        // credits withheld, pool spent and queue filled
        withhold = 1'b1;
        base = received;
        for (i = 0; i < uart_word_pkg::credit_max + uart_word_pkg::queue_depth; i++) begin
            send_word();
        end
        collect_words(base + uart_word_pkg::credit_max, "withheld burst");
        expect_count(received - base, uart_word_pkg::credit_max, "words without returns");
        @(negedge clk);
        assert (!overflow) else begin
            value_errors++;
            $display("FAIL %0t: overflow set before the queue was full", $time);
        end
        // one word too many
        send_word();
        watch_overflow();
        expect_count(dropped, 1, "dropped words");

        // returns resume, queued words follow in order
        @(posedge clk);
        withhold = 1'b0;
        drain_expected("queued words");
        expect_count(received - base, uart_word_pkg::credit_max + uart_word_pkg::queue_depth,
                     "words after resume");
        for (i = 0; i < 6; i++) begin
            send_word();
        end
        drain_expected("traffic after overflow");
        settle_credits();

        // spend some credits, leave a lone low byte, then reset
        withhold = 1'b1;
        base = received;
        send_word();
        send_word();
        collect_words(base + 2, "words before reset");
        send_byte(8'($random(seed)), 1'b0);
        idle_bits(2);
        assert (overflow) else begin
            value_errors++;
            $display("FAIL %0t: overflow cleared without a reset", $time);
        end
        pulse_reset();
        assert (!word_valid && !overflow) else begin
            value_errors++;
            $display("FAIL %0t: word_valid %b overflow %b after reset", $time,
                     word_valid, overflow);
        end

        // full pool again, pairing starts over
        @(posedge clk);
        base = received;
        for (i = 0; i <= uart_word_pkg::credit_max; i++) begin
            send_word();
        end
        collect_words(base + uart_word_pkg::credit_max, "words after reset");
        idle_bits(2);
        @(posedge clk);
        expect_count(received - base, uart_word_pkg::credit_max, "words after reset");
        withhold = 1'b0;
        drain_expected("release after reset");
        for (i = 0; i < 4; i++) begin
            send_word();
        end
        drain_expected("final traffic");
        expect_count(dropped, 1, "dropped words at end");

        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
hdl/uart_word_pkg.sv
hdl/uart_rx.sv
hdl/uart_word_asm.sv
hdl/word_credit_tx.sv
hdl/uart_word_top.sv
tests/tb_uart_word_top.sv

// File: Makefile
# Verilator flow for the serial word receiver

VERILATOR ?= verilator
TOP       ?= tb_uart_word_top
RTL_TOP   ?= uart_word_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= SIMULATION PASSED

SRCS      := $(shell cat $(FILELIST))
RTL_SRCS  := $(filter hdl/%,$(SRCS))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# RTL on its own, then the whole list with the testbench
lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(VFLAGS) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) $(VFLAGS) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(BUILD_DIR) $(VFLAGS) -f $(FILELIST)

# pass only when the pass message shows up in the run output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
